/* dv/tb_clk_gen.sv */
// Clock and reset source for the write-back table testbench
// 100 ns clock, reset held low for the first 8 rising edges

`timescale 1ns/1ps

module tb_clk_gen (
  output logic wb_clk,
  output logic cpurst_b
);

  localparam int HALF_PERIOD = 50;
  localparam int RST_CYCLES  = 8;

  // Free running clock
  initial
  begin
    wb_clk = 1'b0;
    forever
      #(HALF_PERIOD) wb_clk = ~wb_clk;
  end

  // Release just after an edge, away from the sampling point
  initial
  begin
    cpurst_b = 1'b0;
    repeat (RST_CYCLES) @(posedge wb_clk);
    #1;
    cpurst_b = 1'b1;
  end

endmodule

/* dv/vwbt_patterns.txt */
# One clock cycle per line, all fields hex
# cv cp ct  w0v w0p  w1v w1p  fl  rd0 rd1 rd2  exp0 exp1 exp2
# Status word bits: 2 count, 1 type (1 = load/store), 0 valid
# Reset state
0 00 0  0 00  0 00  0  00 01 02  1 1 1
0 00 0  0 00  0 00  0  1d 1e 1f  1 1 1
0 00 0  0 00  0 00  0  0a 0b 10  1 1 1
# ALU create, write-back bypass
1 05 0  0 00  0 00  0  05 06 07  1 1 1
0 00 0  0 00  0 00  0  05 06 07  0 1 1
0 00 0  1 05  0 00  0  05 05 06  1 1 1
0 00 0  0 00  0 00  0  05 04 06  1 1 1
# Load/store renamed onto pending register 08
1 08 0  0 00  0 00  0  08 09 05  1 1 1
1 08 1  0 00  0 00  0  08 09 05  0 1 1
0 00 0  0 00  0 00  0  08 09 05  6 1 1
0 00 0  1 08  0 00  0  08 00 01  6 1 1
0 00 0  0 00  0 00  0  08 00 01  2 1 1
0 00 0  0 00  1 08  0  08 07 05  3 1 1
0 00 0  0 00  0 00  0  08 05 1f  3 1 1
# Load/store create onto a valid register keeps count 0
1 0c 1  0 00  0 00  0  0c 08 05  1 3 1
0 00 0  0 00  0 00  0  0c 08 0d  2 3 1
# Create and write-back to the same register
1 11 0  0 00  0 00  0  11 0c 12  1 2 1
1 11 1  1 11  0 00  0  11 0c 12  1 2 1
0 00 0  0 00  0 00  0  11 0c 12  2 2 1
# Both ports retire two registers
0 00 0  1 0c  1 11  0  0c 11 05  3 3 1
0 00 0  0 00  0 00  0  0c 11 08  3 3 3
# Flush with pending entries and other requests
1 01 0  0 00  0 00  0  01 02 03  1 1 1
1 02 0  0 00  0 00  0  01 02 03  0 1 1
1 03 1  0 00  0 00  0  01 02 03  0 0 1
1 02 1  0 00  0 00  0  01 02 03  0 0 2
0 00 0  0 00  0 00  0  01 02 03  0 6 2
1 04 1  1 01  1 03  1  01 02 03  0 6 2
0 00 0  0 00  0 00  0  01 02 03  1 1 1
0 00 0  0 00  0 00  0  04 05 08  1 1 1
0 00 0  0 00  0 00  0  0c 11 1f  1 1 1
# Leave pending entries for the random read phase
1 0a 1  0 00  0 00  0  0a 15 1b  1 1 1
1 0a 1  0 00  0 00  0  0a 15 1b  2 1 1
1 15 0  0 00  0 00  0  0a 15 1b  6 1 1
1 1b 1  0 00  0 00  0  0a 15 1b  6 0 1
0 00 0  1 15  0 00  0  0a 15 1b  6 1 2
0 00 0  1 0a  0 00  0  0a 15 1b  6 1 2
0 00 0  0 00  0 00  0  0a 15 1b  2 1 2

/* dv/vwbt_tb.sv */
// Testbench for the vector write-back table
// Replays dv/vwbt_patterns.txt one cycle per line, then runs idle cycles
// with random read indices checked against a reference model of the table

`timescale 1ns/1ps

`include "vwbt_defs.svh"

module vwbt_tb;

  import vwbt_pkg::*;

  // Drive just after the edge, check just before the next one
  localparam int DRIVE_DLY   = 1;
  localparam int CHECK_DLY   = 97;
  localparam int RST_TIMEOUT = 20;
  localparam int MAX_LINES   = 200;
  localparam int IDLE_CYCLES = 40;

  logic       wb_clk;
  logic       cpurst_b;
  logic       create_vld;
  vreg_idx_t  create_preg;
  prod_type_t create_type;
  logic       wb0_vld;
  vreg_idx_t  wb0_preg;
  logic       wb1_vld;
  vreg_idx_t  wb1_preg;
  logic       flush;
  vreg_idx_t  rd_preg0;
  vreg_idx_t  rd_preg1;
  vreg_idx_t  rd_preg2;
  wbt_stat_t  rd_stat0;
  wbt_stat_t  rd_stat1;
  wbt_stat_t  rd_stat2;

  // One reference model slot per entry
  logic m_vld  [`VWBT_ENTRIES];
  logic m_type [`VWBT_ENTRIES];
  logic m_cnt  [`VWBT_ENTRIES];

  // Error counts for pattern, model and other failures
  int     pat_err;
  int     mdl_err;
  int     oth_err;
  integer seed;
  logic   timed_out;

  tb_clk_gen u_clk_gen (
    .wb_clk   (wb_clk),
    .cpurst_b (cpurst_b)
  );

  vwbt_top dut_i (
    .wb_clk      (wb_clk),
    .cpurst_b    (cpurst_b),
    .create_vld  (create_vld),
    .create_preg (create_preg),
    .create_type (create_type),
    .wb0_vld     (wb0_vld),
    .wb0_preg    (wb0_preg),
    .wb1_vld     (wb1_vld),
    .wb1_preg    (wb1_preg),
    .flush       (flush),
    .rd_preg0    (rd_preg0),
    .rd_preg1    (rd_preg1),
    .rd_preg2    (rd_preg2),
    .rd_stat0    (rd_stat0),
    .rd_stat1    (rd_stat1),
    .rd_stat2    (rd_stat2)
  );

  // ---------------------------------------------------------------------------
  // Reference model
  // ---------------------------------------------------------------------------
  // Either port retiring this entry while no flush is present
  function automatic logic wb_hit_of(vreg_idx_t idx);
    return !flush && ((wb0_vld && (wb0_preg == idx)) ||
                      (wb1_vld && (wb1_preg == idx)));
  endfunction

  // Expected status word with the retiring write-back in valid
  function automatic wbt_stat_t model_stat(vreg_idx_t idx);
    wbt_stat_t s;
    s = '0;
    s[`VWBT_VEC_VLD]  = m_vld[idx] || (wb_hit_of(idx) && !m_cnt[idx]);
    s[`VWBT_VEC_TYPE] = m_type[idx];
    s[`VWBT_VEC_CNT]  = m_cnt[idx];
    return s;
  endfunction

  task automatic model_reset();
    for (int i = 0; i < `VWBT_ENTRIES; i++)
    begin
      m_vld[i]  = 1'b1;
      m_type[i] = 1'b0;
      m_cnt[i]  = 1'b0;
    end
  endtask

  // Apply the entry rule for the coming edge with flush first
  task automatic model_step();
    vreg_idx_t idx;
    logic      c_hit;
    logic      w_hit;
    for (int i = 0; i < `VWBT_ENTRIES; i++)
    begin
      idx   = vreg_idx_t'(i);
      c_hit = !flush && create_vld && (create_preg == idx);
      w_hit = wb_hit_of(idx);
      if (flush)
      begin
        m_vld[i]  = 1'b1;
        m_type[i] = 1'b0;
        m_cnt[i]  = 1'b0;
      end
      else if (c_hit)
      begin
        // Second producer only for load/store onto a pending register
        m_cnt[i]  = !m_vld[i] && !w_hit && (create_type == `VWBT_TYPE_VLSU);
        m_vld[i]  = 1'b0;
        m_type[i] = create_type;
      end
      else if (w_hit)
      begin
        if (m_cnt[i])
          m_cnt[i] = 1'b0;
        else
          m_vld[i] = 1'b1;
      end
    end
  endtask

  // ---------------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------------
  task automatic check_port(int port, vreg_idx_t idx, wbt_stat_t got,
                            wbt_stat_t exp, logic from_file);
    assert (got === exp)
    else
    begin
      if (from_file)
        pat_err++;
      else
        mdl_err++;
      $display("error %0t: port %0d reg %0d read %h expected %h from %s",
               $time, port, idx, got, exp, from_file ? "pattern" : "model");
    end
  endtask

  // Model check on every cycle and file values where given
  task automatic check_reads(logic use_file, wbt_stat_t e0, wbt_stat_t e1,
                             wbt_stat_t e2);
    check_port(0, rd_preg0, rd_stat0, model_stat(rd_preg0), 1'b0);
    check_port(1, rd_preg1, rd_stat1, model_stat(rd_preg1), 1'b0);
    check_port(2, rd_preg2, rd_stat2, model_stat(rd_preg2), 1'b0);
    if (use_file)
    begin
      check_port(0, rd_preg0, rd_stat0, e0, 1'b1);
      check_port(1, rd_preg1, rd_stat1, e1, 1'b1);
      check_port(2, rd_preg2, rd_stat2, e2, 1'b1);
    end
  endtask

  // ---------------------------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------------------------
  task automatic clear_requests();
    create_vld  = 1'b0;
    create_preg = '0;
    create_type = 1'b0;
    wb0_vld     = 1'b0;
    wb0_preg    = '0;
    wb1_vld     = 1'b0;
    wb1_preg    = '0;
    flush       = 1'b0;
  endtask

  task automatic wait_for_reset(output logic to);
    int cycles;
    cycles = 0;
    to     = 1'b0;
    while (cpurst_b !== 1'b1 && cycles < RST_TIMEOUT)
    begin
      @(posedge wb_clk);
      cycles++;
    end
    if (cpurst_b !== 1'b1)
    begin
      $display("Timeout: reset still active after %0d cycles", RST_TIMEOUT);
      oth_err++;
      to = 1'b1;
    end
  endtask

  // Every register read once while the table is still in reset state
  task automatic sweep_reset_state();
    for (int i = 0; i < `VWBT_ENTRIES; i += 3)
    begin
      @(posedge wb_clk);
      #(DRIVE_DLY);
      clear_requests();
      rd_preg0 = vreg_idx_t'(i);
      rd_preg1 = vreg_idx_t'(i + 1);
      rd_preg2 = vreg_idx_t'(i + 2);
      #(CHECK_DLY);
      check_reads(1'b0, '0, '0, '0);
      model_step();
    end
  endtask

  // One pattern line per cycle with comments and blank lines skipped
  task automatic run_patterns(output logic to);
    int    fd;
    int    n;
    int    lines;
    string line;
    int    cv;
    int    cp;
    int    ct;
    int    w0v;
    int    w0p;
    int    w1v;
    int    w1p;
    int    fl;
    int    r0;
    int    r1;
    int    r2;
    int    e0;
    int    e1;
    int    e2;
    to    = 1'b0;
    lines = 0;
    fd    = $fopen("dv/vwbt_patterns.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the pattern file dv/vwbt_patterns.txt");
      oth_err++;
    end
    else
    begin
      while (!$feof(fd) && lines < MAX_LINES)
      begin
        n = $fgets(line, fd);
        lines++;
        if (n > 1 && line.getc(0) != "#")
        begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      cv, cp, ct, w0v, w0p, w1v, w1p, fl, r0, r1, r2, e0, e1, e2);
          if (n != 14)
          begin
            $display("Pattern line %0d has %0d fields instead of 14", lines, n);
            oth_err++;
          end
          else
          begin
            @(posedge wb_clk);
            #(DRIVE_DLY);
            create_vld  = cv[0];
            create_preg = cp[4:0];
            create_type = ct[0];
            wb0_vld     = w0v[0];
            wb0_preg    = w0p[4:0];
            wb1_vld     = w1v[0];
            wb1_preg    = w1p[4:0];
            flush       = fl[0];
            rd_preg0    = r0[4:0];
            rd_preg1    = r1[4:0];
            rd_preg2    = r2[4:0];
            #(CHECK_DLY);
            check_reads(1'b1, e0[2:0], e1[2:0], e2[2:0]);
            model_step();
          end
        end
      end
      if (!$feof(fd))
      begin
        $display("Timeout: pattern file not done after %0d lines", MAX_LINES);
        oth_err++;
        to = 1'b1;
      end
      $fclose(fd);
    end
  endtask

  // Random operand reads on an idle table against the model
  task automatic run_idle();
    repeat (IDLE_CYCLES)
    begin
      @(posedge wb_clk);
      #(DRIVE_DLY);
      clear_requests();
      rd_preg0 = vreg_idx_t'($random(seed));
      rd_preg1 = vreg_idx_t'($random(seed));
      rd_preg2 = vreg_idx_t'($random(seed));
      #(CHECK_DLY);
      check_reads(1'b0, '0, '0, '0);
      model_step();
    end
  endtask

  // ---------------------------------------------------------------------------
  // Main sequence
  // ---------------------------------------------------------------------------
  initial
  begin
    seed      = 32'h195a;
    pat_err   = 0;
    mdl_err   = 0;
    oth_err   = 0;
    timed_out = 1'b0;
    clear_requests();
    rd_preg0  = '0;
    rd_preg1  = '0;
    rd_preg2  = '0;
    model_reset();
    wait_for_reset(timed_out);
    if (!timed_out)
      sweep_reset_state();
    if (!timed_out)
      run_patterns(timed_out);
    if (!timed_out)
      run_idle();
    $display("Errors: %0d pattern, %0d model, %0d other", pat_err, mdl_err, oth_err);
    if (pat_err + mdl_err + oth_err == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* list.f */
+incdir+source
source/vwbt_pkg.sv
source/vwbt_if.sv
source/vwbt_ctrl.sv
source/vwbt_entry.sv
source/vwbt_read_mux.sv
source/vwbt_top.sv
dv/tb_clk_gen.sv
dv/vwbt_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the vector write-back table testbench with Verilator
# Exit status is 0 only when the log shows no failure

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=vwbt_sim
LOG_FILE=sim.log

echo "Compiling with Verilator"
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module vwbt_tb -Mdir "$BUILD_DIR" -o "$SIM_BIN" -f list.f
if [ $? -ne 0 ]; then
  echo "Compile failed"
  exit 1
fi

echo "Running simulation"
"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulator returned status $sim_status"
  exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG_FILE"; then
  exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG_FILE"; then
  echo "No result line found in $LOG_FILE"
  exit 1
fi
exit 0

/* source/vwbt_ctrl.sv */
// Request decode for the vector write-back table
// Turns create and write-back indices into one-hot strobes for the entries
// and checks the write-back request rules; the datapath is combinational

`timescale 1ns/1ps

module vwbt_ctrl (
  input  logic                  wb_clk,
  input  logic                  cpurst_b,
  input  logic                  create_vld,
  input  vwbt_pkg::vreg_idx_t   create_preg,
  input  vwbt_pkg::prod_type_t  create_type,
  input  logic                  wb0_vld,
  input  vwbt_pkg::vreg_idx_t   wb0_preg,
  input  logic                  wb1_vld,
  input  vwbt_pkg::vreg_idx_t   wb1_preg,
  input  logic                  flush,
  input  vwbt_pkg::entry_vec_t  pend,
  vwbt_if.ctrl                  ctl
);

  import vwbt_pkg::*;

  entry_vec_t create_dec;
  entry_vec_t wb0_dec;
  entry_vec_t wb1_dec;

  // ---------------------------------------------------------------------------
  // Index decode
  // ---------------------------------------------------------------------------
  // Shift a single one into place, zero when the request is idle
  assign create_dec = create_vld ? (entry_vec_t'(1) << create_preg) : '0;
  assign wb0_dec    = wb0_vld ? (entry_vec_t'(1) << wb0_preg) : '0;
  assign wb1_dec    = wb1_vld ? (entry_vec_t'(1) << wb1_preg) : '0;

  // ---------------------------------------------------------------------------
  // Strobes to the entries
  // ---------------------------------------------------------------------------
  // Flush wins over everything, so drop the other requests
  assign ctl.create_en   = flush ? '0 : create_dec;
  // Both ports share one strobe per entry
  assign ctl.wb_en       = flush ? '0 : (wb0_dec | wb1_dec);
  assign ctl.create_type = create_type;
  assign ctl.flush       = flush;

  // ---------------------------------------------------------------------------
  // Request rules
  // ---------------------------------------------------------------------------
  // Two ports on one register would lose a producer count
  a_wb_dup : assert property (
    @(posedge wb_clk) disable iff (!cpurst_b)
    !(wb0_vld && wb1_vld && !flush && (wb0_preg == wb1_preg))
  )
    else $error("write-back ports 0 and 1 name register %0d", wb0_preg);

  // Entry must be pending, pend comes back from the entry state
  a_wb_pend : assert property (
    @(posedge wb_clk) disable iff (!cpurst_b)
    (ctl.wb_en & ~pend) == '0
  )
    else $error("write-back to non-pending entries %h", ctl.wb_en & ~pend);

endmodule

/* source/vwbt_defs.svh */
// Sizes and encodings for the vector write-back table
// Include wherever entry count, index width or status bits are needed

`ifndef VWBT_DEFS_SVH
`define VWBT_DEFS_SVH

// Table geometry, one entry per physical vector register
`define VWBT_ENTRIES    32
`define VWBT_IDX_W      5

// ---------------------------------------------------------------------------
// Status word layout
// ---------------------------------------------------------------------------
// Written back, or retiring this cycle
`define VWBT_VEC_VLD    0
// Producer type of the last create
`define VWBT_VEC_TYPE   1
// Second producer still outstanding
`define VWBT_VEC_CNT    2

// Producer type code for load/store, ordinary ALU producer is 0
`define VWBT_TYPE_VLSU  1'b1

`endif

/* source/vwbt_entry.sv */
// One entry of the vector write-back table
// Holds written-back flag, producer type and outstanding-producer count
// and forms the entry's status word with same-cycle write-back bypass

`timescale 1ns/1ps

`include "vwbt_defs.svh"

module vwbt_entry (
  input  logic                 wb_clk,
  input  logic                 cpurst_b,
  vwbt_if.entry                ctl,
  input  int                   sel,
  output vwbt_pkg::wbt_stat_t  stat,
  output logic                 pend
);

  import vwbt_pkg::*;

  logic       wb_flag;
  prod_type_t inst_type;
  logic       cnt;
  logic       create_hit;
  logic       wb_hit;
  logic       cnt_nxt;

  // This entry's bit of the shared strobes
  assign create_hit = ctl.create_en[sel];
  assign wb_hit     = ctl.wb_en[sel];

  // ---------------------------------------------------------------------------
  // Written-back flag
  // ---------------------------------------------------------------------------
  always_ff @(posedge wb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      wb_flag <= 1'b1;
    else if (ctl.flush)
      wb_flag <= 1'b1;
    else if (create_hit)
      wb_flag <= 1'b0;
    // Last producer retires
    else if (wb_hit && !cnt)
      wb_flag <= 1'b1;
  end

  // ---------------------------------------------------------------------------
  // Producer type
  // ---------------------------------------------------------------------------
  always_ff @(posedge wb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      inst_type <= 1'b0;
    else if (ctl.flush)
      inst_type <= 1'b0;
    else if (create_hit)
      inst_type <= ctl.create_type;
  end

  // ---------------------------------------------------------------------------
  // Outstanding-producer counter
  // ---------------------------------------------------------------------------
  // Count up only for a load/store renamed onto a still pending register
  assign cnt_nxt = !wb_flag && !wb_hit && create_hit
                   && (ctl.create_type == `VWBT_TYPE_VLSU);

  always_ff @(posedge wb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cnt <= 1'b0;
    else if (ctl.flush)
      cnt <= 1'b0;
    else if (create_hit || wb_hit)
      cnt <= cnt_nxt;
  end

  // Status word, valid also set by a retiring write-back this cycle
  assign stat[`VWBT_VEC_VLD]  = wb_flag || (wb_hit && !cnt);
  assign stat[`VWBT_VEC_TYPE] = inst_type;
  assign stat[`VWBT_VEC_CNT]  = cnt;
  assign pend                 = !wb_flag;

  // Second producer only exists while pending
  a_cnt_pend : assert property (
    @(posedge wb_clk) disable iff (!cpurst_b) !(wb_flag && cnt)
  )
    else $error("entry %0d has count set while written back", sel);

endmodule

/* source/vwbt_if.sv */
// Per-entry create and write-back controls of the write-back table
// The control block drives it, every entry picks out its own bit

`timescale 1ns/1ps

interface vwbt_if;

  import vwbt_pkg::*;

  // One-hot create strobe and the type to latch
  entry_vec_t create_en;
  prod_type_t create_type;

  // Merged write-back strobes of both ports
  entry_vec_t wb_en;

  // Table-wide return to written-back state
  logic       flush;

  // Control side
  modport ctrl (
    output create_en,
    output create_type,
    output wb_en,
    output flush
  );

  // Entry side
  modport entry (
    input  create_en,
    input  create_type,
    input  wb_en,
    input  flush
  );

endinterface

/* source/vwbt_pkg.sv */
// Shared types for the vector write-back table
// Used by the RTL and the testbench through a wildcard import

`include "vwbt_defs.svh"

package vwbt_pkg;

  // Physical vector register index
  typedef logic [`VWBT_IDX_W-1:0] vreg_idx_t;

  // Producer type, 0 ALU, 1 load/store
  typedef logic prod_type_t;

  // Status word returned by the read ports
  // Bit positions come from the VWBT_VEC_* macros
  typedef logic [2:0] wbt_stat_t;

  // One bit per table entry
  typedef logic [`VWBT_ENTRIES-1:0] entry_vec_t;

endpackage

/* source/vwbt_read_mux.sv */
// Operand read ports of the vector write-back table
// Three independent selections of an entry's status word by register index,
// combinational from the index and the entry state

`timescale 1ns/1ps

`include "vwbt_defs.svh"

module vwbt_read_mux (
  input  vwbt_pkg::wbt_stat_t  stat_arr [`VWBT_ENTRIES],
  input  vwbt_pkg::vreg_idx_t  rd_preg0,
  input  vwbt_pkg::vreg_idx_t  rd_preg1,
  input  vwbt_pkg::vreg_idx_t  rd_preg2,
  output vwbt_pkg::wbt_stat_t  rd_stat0,
  output vwbt_pkg::wbt_stat_t  rd_stat1,
  output vwbt_pkg::wbt_stat_t  rd_stat2
);

  import vwbt_pkg::*;

  // ---------------------------------------------------------------------------
  // Status selection
  // ---------------------------------------------------------------------------
  // Index width covers the table exactly, no range check needed
  assign rd_stat0 = stat_arr[rd_preg0];
  assign rd_stat1 = stat_arr[rd_preg1];
  assign rd_stat2 = stat_arr[rd_preg2];

  // ---------------------------------------------------------------------------
  // Index checks
  // ---------------------------------------------------------------------------
  // Unknown index would hide a wrong operand status
  always_comb
  begin
    a_rd0_known : assert (!$isunknown(rd_preg0))
      else $error("read port 0 index unknown");
    a_rd1_known : assert (!$isunknown(rd_preg1))
      else $error("read port 1 index unknown");
    a_rd2_known : assert (!$isunknown(rd_preg2))
      else $error("read port 2 index unknown");
  end

endmodule

/* source/vwbt_top.sv */
// Top level of the vector write-back table
// Decode allocates with create, two ports retire producers, flush clears
// the table and three read ports return status words to operand decode

`timescale 1ns/1ps

`include "vwbt_defs.svh"

module vwbt_top (
  input  logic                  wb_clk,
  input  logic                  cpurst_b,
  input  logic                  create_vld,
  input  vwbt_pkg::vreg_idx_t   create_preg,
  input  vwbt_pkg::prod_type_t  create_type,
  input  logic                  wb0_vld,
  input  vwbt_pkg::vreg_idx_t   wb0_preg,
  input  logic                  wb1_vld,
  input  vwbt_pkg::vreg_idx_t   wb1_preg,
  input  logic                  flush,
  input  vwbt_pkg::vreg_idx_t   rd_preg0,
  input  vwbt_pkg::vreg_idx_t   rd_preg1,
  input  vwbt_pkg::vreg_idx_t   rd_preg2,
  output vwbt_pkg::wbt_stat_t   rd_stat0,
  output vwbt_pkg::wbt_stat_t   rd_stat1,
  output vwbt_pkg::wbt_stat_t   rd_stat2
);

  import vwbt_pkg::*;

  // Per-entry status words and pending flags
  wbt_stat_t  stat_arr [`VWBT_ENTRIES];
  entry_vec_t pend;

  // Strobes from decode to the entries
  vwbt_if wbt_if ();

  // ---------------------------------------------------------------------------
  // Request decode
  // ---------------------------------------------------------------------------
  vwbt_ctrl u_ctrl (
    .wb_clk      (wb_clk),
    .cpurst_b    (cpurst_b),
    .create_vld  (create_vld),
    .create_preg (create_preg),
    .create_type (create_type),
    .wb0_vld     (wb0_vld),
    .wb0_preg    (wb0_preg),
    .wb1_vld     (wb1_vld),
    .wb1_preg    (wb1_preg),
    .flush       (flush),
    .pend        (pend),
    .ctl         (wbt_if.ctrl)
  );

  // ---------------------------------------------------------------------------
  // Table entries
  // ---------------------------------------------------------------------------
  for (genvar i = 0; i < `VWBT_ENTRIES; i++)
  begin : g_entry
    vwbt_entry u_entry (
      .wb_clk   (wb_clk),
      .cpurst_b (cpurst_b),
      .ctl      (wbt_if.entry),
      .sel      (i),
      .stat     (stat_arr[i]),
      .pend     (pend[i])
    );
  end

  // Operand status read
  vwbt_read_mux u_read_mux (
    .stat_arr (stat_arr),
    .rd_preg0 (rd_preg0),
    .rd_preg1 (rd_preg1),
    .rd_preg2 (rd_preg2),
    .rd_stat0 (rd_stat0),
    .rd_stat1 (rd_stat1),
    .rd_stat2 (rd_stat2)
  );

endmodule
